// File: verilog/mul_pkg.sv
/*
 * Shared widths, encodings and structs of the RV64M multiply lane.
 * Only MUL, MULH, MULHSU, MULHU and MULW are covered; no divide.
 * Struct fields are listed MSB first, so field order matters to
 * anything that packs or unpacks these words by hand.
 */

package mul_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    localparam int XLEN   = 64;  // RV64 data width
    localparam int REG_AW = 5;   // x0..x31
    localparam int TAG_W  = 6;   // Issue tag that wraps around

    // ------------------------------
    // Instruction encodings
    // ------------------------------

    localparam logic [6:0] OPC_OP        = 7'b0110011;  // 64-bit R-type
    localparam logic [6:0] OPC_OP32      = 7'b0111011;  // R-type word ops
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension

    // Operation code whose low values follow funct3 of the multiply group
    typedef enum logic [2:0] {
        MUL_LO    = 3'd0,  // MUL, MULW
        MUL_HI_SS = 3'd1,  // MULH
        MUL_HI_SU = 3'd2,  // MULHSU
        MUL_HI_UU = 3'd3,  // MULHU
        MUL_NONE  = 3'd7   // Empty stage
    } mul_op_e;

    // ------------------------------
    // Port payloads
    // ------------------------------

    // Word offered by the issuer
    typedef struct packed {
        logic [31:0]      instr;
        logic [TAG_W-1:0] tag;
    } issue_t;

    // Decoded request with operands read from the register file
    typedef struct packed {
        logic              valid;
        mul_op_e           op;
        logic              op_32;  // MULW
        logic [REG_AW-1:0] rd;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
    } mul_req_t;

    // Result going back to the register file and out of the lane
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   data;
    } wb_t;

    // External preload of a register
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } rf_load_t;

endpackage

// File: verilog/mul_decode.sv
/*
 * Decoder for the RV64M multiply group with a one-bit issue interlock.
 * Non-multiply words are accepted but give an invalid request.
 * Ready drops only for a MULW that follows an accepted 64-bit op.
 * The issuer must hold the word steady while ready is low.
 */

`timescale 1ns/1ps

module mul_decode (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          issue_valid_i,
    input  mul_pkg::issue_t               issue_i,
    output logic                          issue_ready_o,
    output logic [mul_pkg::REG_AW-1:0]    rs1_addr_o,
    output logic [mul_pkg::REG_AW-1:0]    rs2_addr_o,
    input  logic [mul_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [mul_pkg::XLEN-1:0]      rs2_data_i,
    output mul_pkg::mul_req_t             req_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       is_op32;
    logic       is_mul;
    logic       is_mulw;
    logic       issue_fire;
    logic       last_64_q;  // Previous cycle accepted a 64-bit multiply

    // ------------------------------
    // Field extraction
    // ------------------------------

    assign opcode = issue_i.instr[6:0];
    assign funct3 = issue_i.instr[14:12];
    assign funct7 = issue_i.instr[31:25];

    assign rs1_addr_o = issue_i.instr[19:15];
    assign rs2_addr_o = issue_i.instr[24:20];

    assign is_op   = (opcode == mul_pkg::OPC_OP);
    assign is_op32 = (opcode == mul_pkg::OPC_OP32);

    // funct3 0..3 are the multiplies, 4..7 are divide and remainder
    assign is_mul  = (funct7 == mul_pkg::FUNCT7_MULDIV) &
                     ((is_op & ~funct3[2]) | (is_op32 & (funct3 == 3'b000)));
    assign is_mulw = is_mul & is_op32;

    // ------------------------------
    // Issue interlock
    // ------------------------------

    // A MULW right behind a 64-bit op would meet it at the result mux
    assign issue_ready_o = ~(issue_valid_i & is_mulw & last_64_q);
    assign issue_fire    = issue_valid_i & issue_ready_o;

    // Updated every cycle so a held MULW goes through one cycle later
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            last_64_q <= 1'b0;
        end else begin
            last_64_q <= issue_fire & is_mul & ~is_op32;
        end
    end

    // ------------------------------
    // Request to the multiplier
    // ------------------------------

    always_comb begin
        req_o.valid = issue_fire & is_mul;
        req_o.op    = is_mul ? mul_pkg::mul_op_e'(funct3) : mul_pkg::MUL_NONE;
        req_o.op_32 = is_mulw;
        req_o.rd    = issue_i.instr[11:7];
        req_o.tag   = issue_i.tag;
        req_o.src1  = rs1_data_i;  // Operands come back combinationally
        req_o.src2  = rs2_data_i;
    end

endmodule

// File: verilog/mul_regfile.sv
/*
 * 32 x 64-bit integer register file, x0 reads as zero.
 * Two combinational read ports, one writeback port and one load port.
 * Writeback wins when both write in the same cycle; the load is lost.
 */

`timescale 1ns/1ps

module mul_regfile (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [mul_pkg::REG_AW-1:0]    rs1_addr_i,
    input  logic [mul_pkg::REG_AW-1:0]    rs2_addr_i,
    output logic [mul_pkg::XLEN-1:0]      rs1_data_o,
    output logic [mul_pkg::XLEN-1:0]      rs2_data_o,
    input  mul_pkg::wb_t                  wb_i,
    input  mul_pkg::rf_load_t             load_i
);

    logic [mul_pkg::XLEN-1:0]   regs_q [1:31];  // x1..x31
    logic                       wb_we;
    logic                       load_we;
    logic                       wr_en;
    logic [mul_pkg::REG_AW-1:0] wr_addr;
    logic [mul_pkg::XLEN-1:0]   wr_data;

    // ------------------------------
    // Write port select
    // ------------------------------

    assign wb_we   = wb_i.valid & (wb_i.rd != '0);
    assign load_we = load_i.valid & (load_i.addr != '0);

    assign wr_en   = wb_we | load_we;
    assign wr_addr = wb_we ? wb_i.rd   : load_i.addr;
    assign wr_data = wb_we ? wb_i.data : load_i.data;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_addr] <= wr_data;  // wr_addr is never zero here
        end
    end

    // ------------------------------
    // Read ports
    // ------------------------------

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: verilog/mul_unit.sv
/*
 * Two-stage multiplier for MUL, MULH, MULHSU, MULHU and MULW.
 * MULW leaves after one cycle, 64-bit ops after two.
 * There is no back-pressure. The issue side must keep a MULW from issuing
 * right after a 64-bit op, or the stage-1 result is lost at the mux.
 */

`timescale 1ns/1ps

module mul_unit (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                kill_i,     // Flush everything in flight
    input  mul_pkg::mul_req_t   req_i,
    output mul_pkg::wb_t        wb_o
);

    // Stage 0 inputs
    logic                       neg1;
    logic                       neg2;
    logic [mul_pkg::XLEN-1:0]   mag1;
    logic [mul_pkg::XLEN-1:0]   mag2;
    logic                       s0_load;

    // Stage 0 registers
    logic                       s0_valid_q;
    mul_pkg::mul_op_e           s0_op_q;
    logic                       s0_op_32_q;
    logic                       s0_neg_q;
    logic [mul_pkg::REG_AW-1:0] s0_rd_q;
    logic [mul_pkg::TAG_W-1:0]  s0_tag_q;
    logic [mul_pkg::XLEN-1:0]   s0_src1_q;
    logic [mul_pkg::XLEN-1:0]   s0_src2_q;

    // Partial products and MULW result
    logic [95:0]                prod_lo;
    logic [95:0]                prod_hi;
    logic [31:0]                w_res;
    logic [mul_pkg::XLEN-1:0]   w_data;
    logic                       s1_load;

    // Stage 1 registers
    logic                       s1_valid_q;
    mul_pkg::mul_op_e           s1_op_q;
    logic                       s1_neg_q;
    logic [mul_pkg::REG_AW-1:0] s1_rd_q;
    logic [mul_pkg::TAG_W-1:0]  s1_tag_q;
    logic [95:0]                s1_lo_q;
    logic [95:0]                s1_hi_q;

    // Output step
    logic [127:0]               sum_128;
    logic [127:0]               res_128;
    logic [mul_pkg::XLEN-1:0]   res_64;

    // ------------------------------
    // Stage 0, sign handling
    // ------------------------------

    always_comb begin
        case (req_i.op)
            mul_pkg::MUL_LO: begin  // Low word is the same for any signedness
                neg1 = req_i.op_32 ? req_i.src1[31] : req_i.src1[63];
                neg2 = req_i.op_32 ? req_i.src2[31] : req_i.src2[63];
            end
            mul_pkg::MUL_HI_SS: begin
                neg1 = req_i.src1[63];
                neg2 = req_i.src2[63];
            end
            mul_pkg::MUL_HI_SU: begin
                neg1 = req_i.src1[63];
                neg2 = 1'b0;
            end
            default: begin  // MULHU and empty slots
                neg1 = 1'b0;
                neg2 = 1'b0;
            end
        endcase
    end

    assign mag1 = neg1 ? (~req_i.src1 + 64'd1) : req_i.src1;
    assign mag2 = neg2 ? (~req_i.src2 + 64'd1) : req_i.src2;

    // A request in the same cycle as kill is dropped too
    assign s0_load = req_i.valid & ~kill_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s0_valid_q <= 1'b0;
            s0_op_q    <= mul_pkg::MUL_NONE;
            s0_op_32_q <= 1'b0;
            s0_neg_q   <= 1'b0;
            s0_rd_q    <= '0;
            s0_tag_q   <= '0;
            s0_src1_q  <= '0;
            s0_src2_q  <= '0;
        end else begin
            s0_valid_q <= s0_load;
            s0_op_q    <= s0_load ? req_i.op : mul_pkg::MUL_NONE;
            s0_op_32_q <= s0_load & req_i.op_32;
            if (s0_load) begin  // Payload only moves with a real op
                s0_neg_q  <= neg1 ^ neg2;
                s0_rd_q   <= req_i.rd;
                s0_tag_q  <= req_i.tag;
                s0_src1_q <= mag1;
                s0_src2_q <= mag2;
            end
        end
    end

    // ------------------------------
    // Stage 1, partial products
    // ------------------------------

    assign prod_lo = {32'd0, s0_src1_q} * {64'd0, s0_src2_q[31:0]};
    assign prod_hi = {32'd0, s0_src1_q} * {64'd0, s0_src2_q[63:32]};

    // MULW finishes here and needs only the low 32 bits of prod_lo
    assign w_res  = s0_neg_q ? (~prod_lo[31:0] + 32'd1) : prod_lo[31:0];
    assign w_data = {{32{w_res[31]}}, w_res};

    assign s1_load = s0_valid_q & ~s0_op_32_q & ~kill_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s1_op_q    <= mul_pkg::MUL_NONE;
            s1_neg_q   <= 1'b0;
            s1_rd_q    <= '0;
            s1_tag_q   <= '0;
            s1_lo_q    <= '0;
            s1_hi_q    <= '0;
        end else begin
            s1_valid_q <= s1_load;
            s1_op_q    <= s1_load ? s0_op_q : mul_pkg::MUL_NONE;
            if (s1_load) begin
                s1_neg_q <= s0_neg_q;
                s1_rd_q  <= s0_rd_q;
                s1_tag_q <= s0_tag_q;
                s1_lo_q  <= prod_lo;
                s1_hi_q  <= prod_hi;
            end
        end
    end

    // ------------------------------
    // Output step
    // ------------------------------

    // High partial product sits 32 bits up
    assign sum_128 = {32'd0, s1_lo_q} + {s1_hi_q, 32'd0};
    assign res_128 = s1_neg_q ? (~sum_128 + 128'd1) : sum_128;

    always_comb begin
        case (s1_op_q)
            mul_pkg::MUL_LO:    res_64 = res_128[63:0];
            mul_pkg::MUL_HI_SS,
            mul_pkg::MUL_HI_SU,
            mul_pkg::MUL_HI_UU: res_64 = res_128[127:64];
            default:            res_64 = '0;
        endcase
    end

    // Stage-0 MULW has priority and the interlock keeps stage 1 empty then
    always_comb begin
        if (s0_valid_q & s0_op_32_q) begin
            wb_o.valid = 1'b1;
            wb_o.rd    = s0_rd_q;
            wb_o.tag   = s0_tag_q;
            wb_o.data  = w_data;
        end else begin
            wb_o.valid = s1_valid_q;
            wb_o.rd    = s1_rd_q;
            wb_o.tag   = s1_tag_q;
            wb_o.data  = res_64;
        end
    end

endmodule

// File: verilog/mul_exe_top.sv
/*
 * Multiply lane top: register file, decoder and multiplier.
 * No forwarding; a dependent op must wait for the producer's writeback.
 * Load the register file only while no op is in flight.
 */

`timescale 1ns/1ps

module mul_exe_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                issue_valid_i,
    input  mul_pkg::issue_t     issue_i,
    output logic                issue_ready_o,
    input  logic                kill_i,
    input  mul_pkg::rf_load_t   load_i,
    output mul_pkg::wb_t        wb_o
);

    logic [mul_pkg::REG_AW-1:0] rs1_addr;
    logic [mul_pkg::REG_AW-1:0] rs2_addr;
    logic [mul_pkg::XLEN-1:0]   rs1_data;
    logic [mul_pkg::XLEN-1:0]   rs2_data;
    mul_pkg::mul_req_t          mul_req;

    // ------------------------------
    // Decode and operand read
    // ------------------------------

    mul_decode u_decode (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .req_o         (mul_req)
    );

    mul_regfile u_regfile (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_o),      // Result written back on the same edge
        .load_i     (load_i)
    );

    // ------------------------------
    // Multiplier
    // ------------------------------

    mul_unit u_mul (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .kill_i (kill_i),
        .req_i  (mul_req),
        .wb_o   (wb_o)
    );

endmodule

// File: tb/mul_checker.sv
/*
 * Scoreboard for the multiply lane. Samples every port on the falling edge.
 * Expected results follow the RISC-V M rules on its own register file model.
 * Results must show up on wb_o exactly one (MULW) or two cycles after issue.
 * Ready may drop only for a MULW offered right after an accepted 64-bit op.
 * Assumes loads only happen while no result is outstanding.
 */

`timescale 1ns/1ps

module mul_checker (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              issue_valid_i,
    input  mul_pkg::issue_t   issue_i,
    input  logic              issue_ready_i,
    input  logic              kill_i,
    input  mul_pkg::rf_load_t load_i,
    input  mul_pkg::wb_t      wb_i,
    output int                value_errors_o,
    output int                flow_errors_o,
    output int                pending_o
);

    typedef struct packed {
        logic [4:0]  rd;
        logic [5:0]  tag;
        logic [63:0] data;
        logic [31:0] due;   // Falling-edge count when wb_o must carry it
    } expect_t;

    logic [63:0] model_q [0:31];
    expect_t     exp_q [$];
    expect_t     entry;
    expect_t     head;
    logic [31:0] cycle;
    logic        wb_wrote;
    logic        last_64;    // Previous cycle accepted MUL, MULH, MULHSU or MULHU
    logic        exp_ready;
    int          kind;

    // 0..3 is funct3 of OP, 4 is MULW, -1 is anything else
    function automatic int decode_kind(input logic [31:0] instr);
        if (instr[31:25] != mul_pkg::FUNCT7_MULDIV) begin
            return -1;
        end
        if (instr[6:0] == mul_pkg::OPC_OP && !instr[14]) begin
            return int'(instr[13:12]);
        end
        if (instr[6:0] == mul_pkg::OPC_OP32 && instr[14:12] == 3'b000) begin
            return 4;
        end
        return -1;
    endfunction

    function automatic logic [63:0] expected_result(input int k, input logic [63:0] a,
                                                    input logic [63:0] b);
        logic [127:0] xa;
        logic [127:0] xb;
        logic [127:0] prod;
        logic [31:0]  w;
        xa   = {{64{a[63] & (k == 1 || k == 2)}}, a};  // rs1 signed for MULH and MULHSU
        xb   = {{64{b[63] & (k == 1)}}, b};
        prod = xa * xb;  // Low 128 bits are exact in two's complement
        w    = a[31:0] * b[31:0];
        case (k)
            0:       return prod[63:0];
            4:       return {{32{w[31]}}, w};
            default: return prod[127:64];
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
        if (exp_v !== got_v) begin
            value_errors_o++;
            $display("[ERROR] t=%0t %s expected %h observed %h", $time, name, exp_v, got_v);
        end
    endtask

    always @(negedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < 32; r++) begin
                model_q[r] = '0;
            end
            exp_q.delete();
            cycle          = '0;
            last_64        = 1'b0;
            value_errors_o = 0;
            flow_errors_o  = 0;
            pending_o      = 0;
        end else begin
            cycle    = cycle + 32'd1;
            wb_wrote = 1'b0;

            // Operands are read before this cycle's writes land
            kind       = decode_kind(issue_i.instr);
            entry.rd   = issue_i.instr[11:7];
            entry.tag  = issue_i.tag;
            entry.data = expected_result(kind, model_q[issue_i.instr[19:15]],
                                         model_q[issue_i.instr[24:20]]);
            entry.due  = cycle + ((kind == 4) ? 32'd1 : 32'd2);

            // A MULW offered right behind a 64-bit op is held for one cycle
            exp_ready = !(issue_valid_i && kind == 4 && last_64);
            compare_field("issue_ready_o", 64'(exp_ready), 64'(issue_ready_i));

            // ------------------------------
            // Writeback side
            // ------------------------------
            if (wb_i.valid) begin
                if (exp_q.size() == 0) begin
                    flow_errors_o++;
                    $display("Time %0t: writeback to x%0d with tag %0d but no result outstanding",
                             $time, wb_i.rd, wb_i.tag);
                end else begin
                    head = exp_q.pop_front();
                    if (head.due != cycle) begin
                        flow_errors_o++;
                        $display("Time %0t: result with tag %0d came at cycle %0d instead of %0d",
                                 $time, head.tag, cycle, head.due);
                    end
                    compare_field("wb_o.rd", 64'(head.rd), 64'(wb_i.rd));
                    compare_field("wb_o.tag", 64'(head.tag), 64'(wb_i.tag));
                    compare_field("wb_o.data", head.data, wb_i.data);
                    if (head.rd != '0) begin
                        model_q[head.rd] = head.data;
                        wb_wrote         = 1'b1;
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                head = exp_q.pop_front();
                flow_errors_o++;
                $display("Time %0t: result for x%0d with tag %0d never appeared on wb_o",
                         $time, head.rd, head.tag);
            end

            // Writeback wins over a load in the same cycle
            if (load_i.valid && load_i.addr != '0 && !wb_wrote) begin
                model_q[load_i.addr] = load_i.data;
            end

            if (kill_i) begin
                exp_q.delete();  // Whatever is not on wb_o now is flushed
            end else if (issue_valid_i && issue_ready_i && kind >= 0) begin
                exp_q.push_back(entry);
            end
            last_64   = issue_valid_i && issue_ready_i && kind >= 0 && kind <= 3;
            pending_o = exp_q.size();
        end
    end

endmodule

// File: tb/tb_mul_exe.sv
/*
 * Testbench for the multiply lane. A table of load, issue and gap steps
 * is built first and then applied in one loop; mul_checker compares.
 * Loads and gaps wait until no result is outstanding, so they never meet
 * a writeback. Random operands use a fixed seed.
 */

`timescale 1ns/1ps

module tb_mul_exe;

    localparam logic [1:0] ACT_LOAD  = 2'd0;
    localparam logic [1:0] ACT_ISSUE = 2'd1;
    localparam logic [1:0] ACT_GAP   = 2'd2;

    localparam logic [2:0] OP_MUL    = 3'd0;  // 0..3 follow funct3
    localparam logic [2:0] OP_MULH   = 3'd1;
    localparam logic [2:0] OP_MULHSU = 3'd2;
    localparam logic [2:0] OP_MULHU  = 3'd3;
    localparam logic [2:0] OP_MULW   = 3'd4;
    localparam logic [2:0] OP_ADD    = 3'd5;
    localparam logic [2:0] OP_DIV    = 3'd6;
    localparam logic [2:0] OP_BAD32  = 3'd7;  // OP32 with funct3 of MULH

    localparam int ISSUE_LIMIT = 16;
    localparam int IDLE_LIMIT  = 64;

    typedef struct packed {
        logic [1:0]  act;
        logic [2:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] val1;  // Loaded into rs1
        logic [63:0] val2;  // Loaded into rs2
        logic        kill;
    } step_t;

    logic              clk_i;
    logic              rstn_i;
    logic              issue_valid_i;
    mul_pkg::issue_t   issue_i;
    logic              issue_ready_o;
    logic              kill_i;
    mul_pkg::rf_load_t load_i;
    mul_pkg::wb_t      wb_o;

    int          value_errors;
    int          flow_errors;
    int          pending;
    int          timeouts;
    logic        stop;
    integer      seed;
    logic [5:0]  next_tag;
    logic [31:0] rnd;
    step_t       cur;
    step_t       table_q [$];
    logic [63:0] corner [0:7];

    mul_exe_top DUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .kill_i        (kill_i),
        .load_i        (load_i),
        .wb_o          (wb_o)
    );

    mul_checker u_checker (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .issue_ready_i  (issue_ready_o),
        .kill_i         (kill_i),
        .load_i         (load_i),
        .wb_i           (wb_o),
        .value_errors_o (value_errors),
        .flow_errors_o  (flow_errors),
        .pending_o      (pending)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------
    // Table building
    // ------------------------------

    function automatic logic [31:0] encode_instr(input logic [2:0] op, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2);
        case (op)
            OP_MULW:  return {7'b0000001, rs2, rs1, 3'b000, rd, mul_pkg::OPC_OP32};
            OP_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, mul_pkg::OPC_OP};
            OP_DIV:   return {7'b0000001, rs2, rs1, 3'b100, rd, mul_pkg::OPC_OP};
            OP_BAD32: return {7'b0000001, rs2, rs1, 3'b001, rd, mul_pkg::OPC_OP32};
            default:  return {7'b0000001, rs2, rs1, op, rd, mul_pkg::OPC_OP};
        endcase
    endfunction

    task automatic load_step(input logic [4:0] ra, input logic [63:0] va,
                             input logic [4:0] rb, input logic [63:0] vb);
        step_t s;
        s = '{act: ACT_LOAD, op: OP_ADD, rd: 5'd0, rs1: ra, rs2: rb,
              val1: va, val2: vb, kill: 1'b0};
        table_q.push_back(s);
    endtask

    task automatic issue_step(input logic [2:0] op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2, input logic kill);
        step_t s;
        s = '{act: ACT_ISSUE, op: op, rd: rd, rs1: rs1, rs2: rs2,
              val1: 64'd0, val2: 64'd0, kill: kill};
        table_q.push_back(s);
    endtask

    task automatic gap_step();
        step_t s;
        s = '{act: ACT_GAP, op: OP_ADD, rd: 5'd0, rs1: 5'd0, rs2: 5'd0,
              val1: 64'd0, val2: 64'd0, kill: 1'b0};
        table_q.push_back(s);
    endtask

    // ------------------------------
    // Driving the DUT
    // ------------------------------

    task automatic apply_load(input logic [4:0] addr, input logic [63:0] data);
        load_i <= '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk_i);
        load_i.valid <= 1'b0;
    endtask

    task automatic send_issue(input logic [31:0] instr, input logic kill);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        issue_valid_i <= 1'b1;
        issue_i       <= '{instr: instr, tag: next_tag};
        kill_i        <= kill;
        while (!taken && waited < ISSUE_LIMIT) begin
            @(negedge clk_i);
            taken = issue_ready_o;  // Word is held while ready is low
            @(posedge clk_i);
            waited++;
        end
        issue_valid_i <= 1'b0;
        kill_i        <= 1'b0;
        next_tag = next_tag + 6'd1;
        if (!taken) begin
            timeouts++;
            stop = 1'b1;
            $display("Timeout: issue_ready_o stayed low for %0d cycles at %0t", waited, $time);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (pending != 0 && waited < IDLE_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            stop = 1'b1;
            $display("Timeout: %0d results still outstanding after %0d cycles", pending, waited);
        end
    endtask

    initial begin
        rstn_i        = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        kill_i        = 1'b0;
        load_i        = '0;
        seed          = 26801;
        timeouts      = 0;
        stop          = 1'b0;
        next_tag      = '0;

        corner[0] = 64'd0;
        corner[1] = 64'd1;
        corner[2] = '1;
        corner[3] = 64'h8000_0000_0000_0000;  // Most negative
        corner[4] = 64'h7FFF_FFFF_FFFF_FFFF;  // Largest positive
        corner[5] = 64'h0000_0000_8000_0000;  // Negative as a word only
        corner[6] = 64'hFFFF_FFFF_7FFF_FFFF;
        corner[7] = 64'hDEAD_BEEF_0123_4567;

        // Every corner pair through all five ops back to back, MULW last
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                load_step(5'd1, corner[i], 5'd2, corner[j]);
                for (int k = 0; k < 5; k++) begin
                    issue_step(3'(k), 5'(3 + k), 5'd1, 5'd2, 1'b0);
                end
            end
        end

        // Interlock in both orders, then a dependent op and rd = x0
        load_step(5'd1, 64'd3, 5'd2, 64'hFFFF_FFFF_FFFF_FFFB);
        issue_step(OP_MULW, 5'd3, 5'd1, 5'd2, 1'b0);
        issue_step(OP_MULHSU, 5'd4, 5'd1, 5'd2, 1'b0);
        issue_step(OP_MULW, 5'd5, 5'd2, 5'd2, 1'b0);
        issue_step(OP_MULW, 5'd6, 5'd1, 5'd1, 1'b0);
        issue_step(OP_MUL, 5'd4, 5'd1, 5'd2, 1'b0);
        gap_step();
        issue_step(OP_MUL, 5'd5, 5'd4, 5'd4, 1'b0);  // Reads x4 after its writeback
        issue_step(OP_MUL, 5'd0, 5'd1, 5'd2, 1'b0);
        gap_step();
        issue_step(OP_MUL, 5'd6, 5'd0, 5'd1, 1'b0);

        // Kill with ops in flight and one issued alongside it
        issue_step(OP_MUL, 5'd8, 5'd1, 5'd2, 1'b0);
        issue_step(OP_MULH, 5'd9, 5'd1, 5'd2, 1'b0);
        issue_step(OP_MULHU, 5'd10, 5'd1, 5'd2, 1'b1);
        gap_step();
        issue_step(OP_MULW, 5'd11, 5'd1, 5'd2, 1'b0);
        issue_step(OP_ADD, 5'd12, 5'd1, 5'd2, 1'b1);
        issue_step(OP_MULHSU, 5'd13, 5'd1, 5'd2, 1'b0);
        gap_step();

        // Words outside the multiply group
        issue_step(OP_ADD, 5'd14, 5'd1, 5'd2, 1'b0);
        issue_step(OP_DIV, 5'd15, 5'd1, 5'd2, 1'b0);
        issue_step(OP_BAD32, 5'd16, 5'd1, 5'd2, 1'b0);
        gap_step();

        // Random operands in x10..x17, results to x20..x27
        for (int r = 0; r < 16; r++) begin
            for (int k = 0; k < 8; k += 2) begin
                load_step(5'(10 + k), {$random(seed), $random(seed)},
                          5'(11 + k), {$random(seed), $random(seed)});
            end
            for (int k = 0; k < 8; k++) begin
                rnd = $random(seed);
                issue_step(3'(rnd[7:0] % 8'd5), 5'd20 + {2'b00, rnd[10:8]},
                           5'd10 + {2'b00, rnd[13:11]}, 5'd10 + {2'b00, rnd[16:14]}, 1'b0);
            end
        end

        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        for (int i = 0; i < table_q.size() && !stop; i++) begin
            cur = table_q[i];
            case (cur.act)
                ACT_LOAD: begin
                    wait_idle();
                    apply_load(cur.rs1, cur.val1);
                    apply_load(cur.rs2, cur.val2);
                end
                ACT_ISSUE: send_issue(encode_instr(cur.op, cur.rd, cur.rs1, cur.rs2), cur.kill);
                default: begin
                    wait_idle();
                    @(posedge clk_i);
                end
            endcase
        end
        wait_idle();
        repeat (3) @(posedge clk_i);

        $display("Errors: %0d value, %0d missing or unexpected, %0d timeout",
                 value_errors, flow_errors, timeouts);
        if (value_errors + flow_errors + timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
verilog/mul_pkg.sv
verilog/mul_decode.sv
verilog/mul_regfile.sv
verilog/mul_unit.sv
verilog/mul_exe_top.sv
tb/mul_checker.sv
tb/tb_mul_exe.sv

// File: Makefile
# Verilator build for the multiply lane testbench

SIM        ?= verilator
TOP        ?= tb_mul_exe
RTL_TOP    ?= mul_exe_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
